// ==== src/ao_periph_pkg.sv ====
// Always-on peripheral package
// Bus structs, address map, register offsets and the byte-strobe merge
`default_nettype none

package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_rsp_t;

  // Single-cycle register access
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } reg_rsp_t;

  // Address layout is base[31:16], zero[15:14], slot[13:12] and offset[11:0]
  localparam logic [15:0] AO_BASE_ADDR = 16'h2000;
  localparam int unsigned SLOT_SEL_LSB = 12;
  localparam int unsigned NUM_SLOTS    = 3;

  typedef enum logic [1:0] {
    SLOT_SOC_CTRL = 2'd0,
    SLOT_FAST_INTR = 2'd1,
    SLOT_GPIO = 2'd2
  } slot_idx_e;

  localparam logic [11:0] SOC_EXIT_VALID_OFFS = 12'h000;
  localparam logic [11:0] SOC_EXIT_VALUE_OFFS = 12'h004;
  localparam logic [11:0] SOC_BOOT_SEL_OFFS   = 12'h008;

  localparam logic [11:0] FI_PENDING_OFFS = 12'h000;
  localparam logic [11:0] FI_ENABLE_OFFS  = 12'h004;

  localparam logic [11:0] GPIO_IN_OFFS      = 12'h000;
  localparam logic [11:0] GPIO_OUT_OFFS     = 12'h004;
  localparam logic [11:0] GPIO_EN_OFFS      = 12'h008;
  localparam logic [11:0] GPIO_INTR_EN_OFFS = 12'h00C;

  // Byte-wise merge of write data into an old value
  function automatic logic [31:0] apply_wstrb(input logic [31:0] old_val,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  wstrb);
    logic [31:0] merged;
    merged = old_val;
    for (int i = 0; i < 4; i++) begin
      if (wstrb[i]) begin
        merged[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== src/obi_reg_bridge.sv ====
// OBI to register bridge
// Grants every request at once and answers one cycle later
`timescale 1ns/1ns
`default_nettype none

module obi_reg_bridge (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::obi_req_t obi_req_i,
  output ao_periph_pkg::obi_rsp_t obi_rsp_o,
  output ao_periph_pkg::reg_req_t reg_req_o,
  input  ao_periph_pkg::reg_rsp_t reg_rsp_i
);

  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        accept;

  // Always ready, so gnt simply mirrors req
  assign accept = obi_req_i.req;

  assign obi_rsp_o.gnt    = obi_req_i.req;
  assign obi_rsp_o.rvalid = rvalid_q;
  assign obi_rsp_o.rdata  = rdata_q;

  // Request path
  assign reg_req_o.valid = accept;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.addr  = obi_req_i.addr[11:0];
  assign reg_req_o.wdata = obi_req_i.wdata;
  assign reg_req_o.wstrb = obi_req_i.be;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  // Writes return zero data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= obi_req_i.we ? 32'h0 : reg_rsp_i.rdata;
    end
  end

  // Every response belongs to a request accepted one cycle earlier
  a_rvalid_follows_accept : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    obi_rsp_o.rvalid |-> $past(obi_req_i.req && obi_rsp_o.gnt)
  ) else $error("rvalid without an accepted request in the previous cycle");

endmodule

`default_nettype wire

// ==== src/ao_reg_demux.sv ====
// Register demultiplexer
// Decodes the access address into a peripheral slot and muxes read data back
`timescale 1ns/1ns
`default_nettype none

module ao_reg_demux (
  input  logic [31:0]                                          addr_i,
  input  ao_periph_pkg::reg_req_t                              reg_req_i,
  output ao_periph_pkg::reg_rsp_t                              reg_rsp_o,
  output ao_periph_pkg::reg_req_t [ao_periph_pkg::NUM_SLOTS-1:0] slot_req_o,
  input  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::NUM_SLOTS-1:0] slot_rsp_i
);

  import ao_periph_pkg::*;

  logic                 base_hit;
  logic                 mapped;
  slot_idx_e            slot_sel;
  logic [NUM_SLOTS-1:0] slot_valid;

  // Bits 15:14 must be zero for a hit
  assign base_hit = (addr_i[31:16] == AO_BASE_ADDR) && (addr_i[15:14] == 2'b00);
  assign slot_sel = slot_idx_e'(addr_i[SLOT_SEL_LSB +: 2]);
  assign mapped   = base_hit && (int'(slot_sel) < NUM_SLOTS);

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_req_o[i]       = reg_req_i;
      slot_req_o[i].valid = reg_req_i.valid && mapped && (slot_sel == slot_idx_e'(i));
      slot_valid[i]       = slot_req_o[i].valid;
      // Unmapped reads fall through as zero
      if (mapped && (slot_sel == slot_idx_e'(i))) begin
        reg_rsp_o.rdata = slot_rsp_i[i].rdata;
      end
    end
  end

  // One slot at most, and only for a live request
  always_comb begin
    a_one_slot : assert final ($onehot0(slot_valid) && (reg_req_i.valid || slot_valid == '0))
      else $error("more than one peripheral slot selected");
  end

endmodule

`default_nettype wire

// ==== src/soc_ctrl.sv ====
// SoC control registers
// Exit flag and value for the testbench, plus synchronized boot-select readback
`timescale 1ns/1ns
`default_nettype none

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output logic [31:0]             exit_value_o
);

  import ao_periph_pkg::*;

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [1:0]  boot_sel_sync_q;
  logic        wr_en;
  logic [31:0] exit_valid_word;
  logic [31:0] exit_value_word;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_comb begin
    exit_valid_word = apply_wstrb({31'b0, exit_valid_q}, reg_req_i.wdata, reg_req_i.wstrb);
    exit_value_word = apply_wstrb(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q    <= 1'b0;
      exit_value_q    <= 32'h0;
      boot_sel_sync_q <= 2'b00;
    end else begin
      boot_sel_sync_q <= {boot_sel_sync_q[0], boot_select_i};
      if (wr_en && reg_req_i.addr == SOC_EXIT_VALID_OFFS) begin
        exit_valid_q <= exit_valid_word[0];
      end
      if (wr_en && reg_req_i.addr == SOC_EXIT_VALUE_OFFS) begin
        exit_value_q <= exit_value_word;
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    case (reg_req_i.addr)
      SOC_EXIT_VALID_OFFS: reg_rsp_o.rdata = {31'b0, exit_valid_q};
      SOC_EXIT_VALUE_OFFS: reg_rsp_o.rdata = exit_value_q;
      SOC_BOOT_SEL_OFFS:   reg_rsp_o.rdata = {31'b0, boot_sel_sync_q[1]};
      default:             reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// ==== src/fast_intr_ctrl.sv ====
// Fast interrupt controller
// Latches fast interrupt lines into a pending register with write-one-to-clear
`timescale 1ns/1ns
`default_nettype none

module fast_intr_ctrl #(
  parameter int unsigned NumFastIntr = 15
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [NumFastIntr-1:0]  fast_intr_i,
  output logic [NumFastIntr-1:0]  fast_intr_o
);

  import ao_periph_pkg::*;

  logic [NumFastIntr-1:0] pending_q;
  logic [NumFastIntr-1:0] enable_q;
  logic [NumFastIntr-1:0] clear_mask;
  logic [31:0]            pending_word;
  logic [31:0]            enable_word;
  logic [31:0]            clear_word;
  logic [31:0]            enable_next;
  logic                   wr_pending;
  logic                   wr_enable;

  assign wr_pending = reg_req_i.valid && reg_req_i.write && reg_req_i.addr == FI_PENDING_OFFS;
  assign wr_enable  = reg_req_i.valid && reg_req_i.write && reg_req_i.addr == FI_ENABLE_OFFS;

  always_comb begin
    pending_word                    = 32'h0;
    pending_word[NumFastIntr-1:0]   = pending_q;
    enable_word                     = 32'h0;
    enable_word[NumFastIntr-1:0]    = enable_q;
    // Only strobed bytes can clear
    clear_word  = apply_wstrb(32'h0, reg_req_i.wdata, reg_req_i.wstrb);
    enable_next = apply_wstrb(enable_word, reg_req_i.wdata, reg_req_i.wstrb);
    clear_mask  = wr_pending ? clear_word[NumFastIntr-1:0] : '0;
  end

  // A line still high wins over the clear
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      pending_q <= (pending_q & ~clear_mask) | fast_intr_i;
      if (wr_enable) begin
        enable_q <= enable_next[NumFastIntr-1:0];
      end
    end
  end

  always_comb begin
    case (reg_req_i.addr)
      FI_PENDING_OFFS: reg_rsp_o.rdata = pending_word;
      FI_ENABLE_OFFS:  reg_rsp_o.rdata = enable_word;
      default:         reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

`default_nettype wire

// ==== src/gpio.sv ====
// GPIO block
// Output, enable and interrupt-enable registers with a two-flop input synchronizer
`timescale 1ns/1ns
`default_nettype none

module gpio #(
  parameter int unsigned GpioWidth = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [GpioWidth-1:0]    gpio_i,
  output logic [GpioWidth-1:0]    gpio_o,
  output logic [GpioWidth-1:0]    gpio_en_o,
  output logic [GpioWidth-1:0]    intr_gpio_o
);

  import ao_periph_pkg::*;

  logic [GpioWidth-1:0] in_meta_q;
  logic [GpioWidth-1:0] in_sync_q;
  logic [GpioWidth-1:0] out_q;
  logic [GpioWidth-1:0] en_q;
  logic [GpioWidth-1:0] intr_en_q;
  logic [31:0]          in_word;
  logic [31:0]          out_word;
  logic [31:0]          en_word;
  logic [31:0]          intr_en_word;
  logic [31:0]          out_next;
  logic [31:0]          en_next;
  logic [31:0]          intr_en_next;
  logic                 wr_en;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_comb begin
    in_word                       = 32'h0;
    in_word[GpioWidth-1:0]        = in_sync_q;
    out_word                      = 32'h0;
    out_word[GpioWidth-1:0]       = out_q;
    en_word                       = 32'h0;
    en_word[GpioWidth-1:0]        = en_q;
    intr_en_word                  = 32'h0;
    intr_en_word[GpioWidth-1:0]   = intr_en_q;
    out_next     = apply_wstrb(out_word, reg_req_i.wdata, reg_req_i.wstrb);
    en_next      = apply_wstrb(en_word, reg_req_i.wdata, reg_req_i.wstrb);
    intr_en_next = apply_wstrb(intr_en_word, reg_req_i.wdata, reg_req_i.wstrb);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      if (wr_en && reg_req_i.addr == GPIO_OUT_OFFS) out_q <= out_next[GpioWidth-1:0];
      if (wr_en && reg_req_i.addr == GPIO_EN_OFFS) en_q <= en_next[GpioWidth-1:0];
      if (wr_en && reg_req_i.addr == GPIO_INTR_EN_OFFS) begin
        intr_en_q <= intr_en_next[GpioWidth-1:0];
      end
    end
  end

  // Input register is read-only
  always_comb begin
    case (reg_req_i.addr)
      GPIO_IN_OFFS:      reg_rsp_o.rdata = in_word;
      GPIO_OUT_OFFS:     reg_rsp_o.rdata = out_word;
      GPIO_EN_OFFS:      reg_rsp_o.rdata = en_word;
      GPIO_INTR_EN_OFFS: reg_rsp_o.rdata = intr_en_word;
      default:           reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_en_o   = en_q;
  assign intr_gpio_o = in_sync_q & intr_en_q;

endmodule

`default_nettype wire

// ==== src/ao_periph_top.sv ====
// Always-on peripheral top level
// OBI bridge, address demux, SoC control, fast interrupt controller and GPIO
`timescale 1ns/1ns
`default_nettype none

module ao_periph_top #(
  parameter int unsigned NumFastIntr = 15,
  parameter int unsigned GpioWidth   = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::obi_req_t obi_req_i,
  output ao_periph_pkg::obi_rsp_t obi_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output logic [31:0]             exit_value_o,
  input  logic [NumFastIntr-1:0]  fast_intr_i,
  output logic [NumFastIntr-1:0]  fast_intr_o,
  input  logic [GpioWidth-1:0]    gpio_i,
  output logic [GpioWidth-1:0]    gpio_o,
  output logic [GpioWidth-1:0]    gpio_en_o,
  output logic [GpioWidth-1:0]    intr_gpio_o
);

  import ao_periph_pkg::*;

  reg_req_t                 periph_req;
  reg_rsp_t                 periph_rsp;
  reg_req_t [NUM_SLOTS-1:0] slot_req;
  reg_rsp_t [NUM_SLOTS-1:0] slot_rsp;

  obi_reg_bridge u_bridge (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .obi_req_i (obi_req_i),
    .obi_rsp_o (obi_rsp_o),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  // Demux sees the full bus address for the base match
  ao_reg_demux u_demux (
    .addr_i     (obi_req_i.addr),
    .reg_req_i  (periph_req),
    .reg_rsp_o  (periph_rsp),
    .slot_req_o (slot_req),
    .slot_rsp_i (slot_rsp)
  );

  soc_ctrl u_soc_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_req_i     (slot_req[SLOT_SOC_CTRL]),
    .reg_rsp_o     (slot_rsp[SLOT_SOC_CTRL]),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  fast_intr_ctrl #(
    .NumFastIntr (NumFastIntr)
  ) u_fast_intr_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (slot_req[SLOT_FAST_INTR]),
    .reg_rsp_o   (slot_rsp[SLOT_FAST_INTR]),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  gpio #(
    .GpioWidth (GpioWidth)
  ) u_gpio (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (slot_req[SLOT_GPIO]),
    .reg_rsp_o   (slot_rsp[SLOT_GPIO]),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_gpio_o (intr_gpio_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_obi_tasks.svh ====
// OBI bus tasks for the always-on peripheral testbench
// Single accesses with grant and response timeouts and a latency check
`ifndef TB_OBI_TASKS_SVH
`define TB_OBI_TASKS_SVH

  // Starts and ends on a falling edge
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata);
    int   waited;
    logic accepted;
    obi_req  = {1'b1, we, addr, wdata, be};
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < BUS_TIMEOUT) begin
      @(posedge clk);
      accepted = obi_rsp.gnt;
      waited++;
    end
    @(negedge clk);
    obi_req = '0;
    rdata   = 32'h0;
    if (!accepted) begin
      $display("Bus request to address %h was never granted", addr);
      error_count++;
    end else begin
      // Grant is due in the cycle of the request
      if (waited != 1) begin
        $display("[ERROR] grant latency: expected 0 actual %0d", waited - 1);
        error_count++;
      end
      // Response is due at the first falling edge after acceptance
      waited = 0;
      while (!obi_rsp.rvalid && waited < BUS_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (!obi_rsp.rvalid) begin
        $display("No bus response for address %h within %0d cycles", addr, BUS_TIMEOUT);
        error_count++;
      end else if (waited != 0) begin
        $display("[ERROR] response latency: expected 1 actual %0d", waited + 1);
        error_count++;
      end
      rdata = obi_rsp.rdata;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be);
    logic [31:0] ignored;
    bus_access(1'b1, addr, wdata, be, ignored);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, 32'h0, 4'hf, rdata);
  endtask

`endif

// ==== dv/tb_ao_periph.sv ====
// Testbench for the always-on peripheral block
// Random register traffic from an LFSR, checked against a register model
`timescale 1ns/1ns
`default_nettype none

module tb_ao_periph;

  import ao_periph_pkg::*;

  localparam int unsigned BUS_TIMEOUT = 16;
  // Writable bits of exit flag, exit value, gpio out and gpio enable
  localparam logic [3:0][31:0] WR_MASK = {32'hff, 32'hff, 32'hffff_ffff, 32'h1};

  logic             clk;
  logic             rst_n;
  obi_req_t         obi_req;
  obi_rsp_t         obi_rsp;
  logic             boot_select;
  logic             exit_valid;
  logic [31:0]      exit_value;
  logic [14:0]      fast_intr_in;
  logic [14:0]      fast_intr_out;
  logic [7:0]       gpio_in;
  logic [7:0]       gpio_out;
  logic [7:0]       gpio_en;
  logic [7:0]       intr_gpio;
  logic [31:0]      lfsr;
  int               error_count;
  int               check_count;
  logic [3:0][31:0] wr_model;
  logic [14:0]      fi_pend_m;
  logic [14:0]      fi_en_m;
  logic [7:0]       gpio_ie_m;

  ao_periph_top u_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .obi_req_i     (obi_req),
    .obi_rsp_o     (obi_rsp),
    .boot_select_i (boot_select),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value),
    .fast_intr_i   (fast_intr_in),
    .fast_intr_o   (fast_intr_out),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .gpio_en_o     (gpio_en),
    .intr_gpio_o   (intr_gpio)
  );

  always #10 clk = ~clk;

  `include "tb_obi_tasks.svh"

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = 32'h0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic logic [31:0] reg_addr(input logic [1:0] slot, input logic [11:0] offs);
    return {AO_BASE_ADDR, 2'b00, slot, offs};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    check_count++;
    if (exp_val !== act_val) begin
      $display("[ERROR] %s: expected %h actual %h", name, exp_val, act_val);
      error_count++;
    end
  endtask

  task automatic check_reset_state();
    compare_value("reset exit_valid_o", 32'h0, {31'b0, exit_valid});
    compare_value("reset gpio_o", 32'h0, {24'b0, gpio_out});
    compare_value("reset gpio_en_o", 32'h0, {24'b0, gpio_en});
    compare_value("reset fast_intr_o", 32'h0, {17'b0, fast_intr_out});
    compare_value("reset intr_gpio_o", 32'h0, {24'b0, intr_gpio});
  endtask

  task automatic strobed_writes();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    logic [3:0]  be;
    logic [1:0]  sel;
    for (int i = 0; i < 40; i++) begin
      data = rand_bits(32);
      be   = rand_bits(4);
      sel  = rand_bits(2);
      case (sel)
        2'd0:    addr = reg_addr(SLOT_SOC_CTRL, SOC_EXIT_VALID_OFFS);
        2'd1:    addr = reg_addr(SLOT_SOC_CTRL, SOC_EXIT_VALUE_OFFS);
        2'd2:    addr = reg_addr(SLOT_GPIO, GPIO_OUT_OFFS);
        default: addr = reg_addr(SLOT_GPIO, GPIO_EN_OFFS);
      endcase
      bus_write(addr, data, be);
      wr_model[sel] = merge_bytes(wr_model[sel], data, be) & WR_MASK[sel];
      bus_read(addr, rd);
      compare_value("strobed write readback", wr_model[sel], rd);
      compare_value("exit_valid_o", {31'b0, wr_model[0][0]}, {31'b0, exit_valid});
      compare_value("exit_value_o", wr_model[1], exit_value);
      compare_value("gpio_o", wr_model[2], {24'b0, gpio_out});
      compare_value("gpio_en_o", wr_model[3], {24'b0, gpio_en});
    end
  endtask

  task automatic fast_interrupts();
    logic [14:0] pattern;
    logic [31:0] data;
    logic [31:0] tmp;
    logic [31:0] rd;
    logic [3:0]  be;
    for (int i = 0; i < 30; i++) begin
      pattern      = rand_bits(15);
      data         = rand_bits(32);
      be           = rand_bits(4);
      // Line is high at the same edge as the write
      fast_intr_in = pattern;
      if (rand_bits(1)) begin
        bus_write(reg_addr(SLOT_FAST_INTR, FI_ENABLE_OFFS), data, be);
        tmp       = merge_bytes({17'b0, fi_en_m}, data, be);
        fi_en_m   = tmp[14:0];
        fi_pend_m = fi_pend_m | pattern;
      end else begin
        bus_write(reg_addr(SLOT_FAST_INTR, FI_PENDING_OFFS), data, be);
        tmp       = merge_bytes(32'h0, data, be);
        fi_pend_m = (fi_pend_m & ~tmp[14:0]) | pattern;
      end
      fast_intr_in = '0;
      bus_read(reg_addr(SLOT_FAST_INTR, FI_PENDING_OFFS), rd);
      compare_value("fast intr pending", {17'b0, fi_pend_m}, rd);
      compare_value("fast_intr_o", {17'b0, fi_pend_m & fi_en_m}, {17'b0, fast_intr_out});
    end
  endtask

  task automatic input_sync();
    logic [31:0] data;
    logic [31:0] tmp;
    logic [31:0] rd;
    logic [3:0]  be;
    for (int i = 0; i < 20; i++) begin
      gpio_in     = rand_bits(8);
      boot_select = rand_bits(1);
      data        = rand_bits(32);
      be          = rand_bits(4);
      bus_write(reg_addr(SLOT_GPIO, GPIO_INTR_EN_OFFS), data, be);
      tmp       = merge_bytes({24'b0, gpio_ie_m}, data, be);
      gpio_ie_m = tmp[7:0];
      @(negedge clk);
      bus_read(reg_addr(SLOT_GPIO, GPIO_IN_OFFS), rd);
      compare_value("gpio input register", {24'b0, gpio_in}, rd);
      bus_read(reg_addr(SLOT_SOC_CTRL, SOC_BOOT_SEL_OFFS), rd);
      compare_value("boot select register", {31'b0, boot_select}, rd);
      compare_value("intr_gpio_o", {24'b0, gpio_in & gpio_ie_m}, {24'b0, intr_gpio});
    end
  endtask

  task automatic timing_and_unmapped();
    logic [31:0] addrs [7];
    logic [31:0] exp_rd [7];
    logic        wes [7];
    logic [31:0] data;
    data   = rand_bits(32);
    addrs  = '{reg_addr(SLOT_GPIO, GPIO_OUT_OFFS), reg_addr(SLOT_GPIO, GPIO_OUT_OFFS),
               reg_addr(2'd3, 12'h004), {16'h2001, 2'b00, 2'd2, GPIO_OUT_OFFS},
               reg_addr(2'd3, 12'h000), {16'h2001, 2'b00, 2'd2, GPIO_OUT_OFFS},
               reg_addr(SLOT_GPIO, GPIO_OUT_OFFS)};
    wes    = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
    exp_rd = '{32'h0, data & 32'hff, 32'h0, 32'h0, 32'h0, 32'h0, data & 32'hff};
    // One request per cycle, each answered in the next cycle
    for (int i = 0; i <= 7; i++) begin
      if (i > 0) begin
        if (!obi_rsp.rvalid) begin
          $display("No response in the cycle after back-to-back request %0d", i - 1);
          error_count++;
        end else if (!wes[i-1]) begin
          compare_value("back-to-back read", exp_rd[i-1], obi_rsp.rdata);
        end
      end
      if (i < 7) begin
        obi_req = {1'b1, wes[i], addrs[i], (i == 0) ? data : ~data, 4'hf};
      end else begin
        obi_req = '0;
      end
      @(negedge clk);
    end
    wr_model[2] = data & 32'hff;
    compare_value("rvalid after burst", 32'h0, {31'b0, obi_rsp.rvalid});
    compare_value("gpio_o after unmapped writes", wr_model[2], {24'b0, gpio_out});
  endtask

  initial begin
    #2_000_000;
    $display("Simulation did not finish within the time limit");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    obi_req      = '0;
    boot_select  = 1'b0;
    fast_intr_in = '0;
    gpio_in      = '0;
    lfsr         = 32'hc415e002;
    error_count  = 0;
    check_count  = 0;
    wr_model     = '0;
    fi_pend_m    = '0;
    fi_en_m      = '0;
    gpio_ie_m    = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_reset_state();
    strobed_writes();
    fast_interrupts();
    input_sync();
    timing_and_unmapped();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
src/ao_periph_pkg.sv
src/obi_reg_bridge.sv
src/ao_reg_demux.sv
src/soc_ctrl.sv
src/fast_intr_ctrl.sv
src/gpio.sv
src/ao_periph_top.sv
dv/tb_ao_periph.sv

// ==== Bender.yml ====
package:
  name: ao_periph

sources:
  - files:
      - src/ao_periph_pkg.sv
      - src/obi_reg_bridge.sv
      - src/ao_reg_demux.sv
      - src/soc_ctrl.sv
      - src/fast_intr_ctrl.sv
      - src/gpio.sv
      - src/ao_periph_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_ao_periph.sv
